// File: common/core_pkg.sv
package core_pkg;

    // data words and byte addresses are both full register width.
    typedef logic [63:0] xlen_t;
    typedef logic [63:0] mask_t;    // one bit per data bit, not per byte.
    typedef logic [5:0]  preg_t;
    typedef logic [4:0]  robidx_t;
    typedef logic [3:0]  ls_size_t; // one-hot: bit 0 byte, 1 half, 2 word, 3 double.
    typedef logic [1:0]  tbus_op_t;

    localparam tbus_op_t tbus_read  = 2'b00;
    localparam tbus_op_t tbus_write = 2'b01;

    // accesses inside this window are MMIO and bypass the trinity bus.
    localparam xlen_t mmio_base  = 64'h0000_0000_3000_0000;
    localparam xlen_t mmio_limit = 64'h0000_0000_4070_0000;

    typedef struct packed {
        preg_t    prd;
        logic     is_load;
        logic     is_store;
        logic     is_unsigned;
        xlen_t    imm;
        xlen_t    src1;
        xlen_t    src2;
        ls_size_t ls_size;
        logic     robidx_flag;
        robidx_t  robidx;
    } ls_instr_t;

    typedef struct packed {
        xlen_t    index;      // byte address.
        xlen_t    write_data;
        mask_t    write_mask;
        tbus_op_t op_type;
    } tbus_req_t;

    typedef struct packed {
        logic    valid;
        logic    need_to_wb;
        preg_t   prd;
        logic    mmio;
        logic    robidx_flag;
        robidx_t robidx;
        xlen_t   data;
    } wb_out_t;

endpackage

// File: memblock/memblock.sv
`timescale 1ns/1ps

module memblock
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      instr_valid,
    input  ls_instr_t instr,
    output logic      instr_ready,
    output logic      mem_stall,
    input  logic      flush_valid,
    input  logic      flush_robidx_flag,
    input  robidx_t   flush_robidx,
    output logic      dcache_flush,
    output logic      req_valid,
    output tbus_req_t req,
    input  logic      req_ready,
    input  logic      done,
    input  xlen_t     read_data,
    output wb_out_t   wb_out
);

    typedef enum logic [1:0] {
        s_idle,
        s_pending,
        s_outstanding
    } ls_state_t;

    ls_state_t  state;
    ls_state_t  state_next;
    xlen_t      ls_address;
    logic       is_mem_op;
    logic       in_mmio;
    logic       mmio_fire;
    logic       mmio_q;
    logic       req_fire;
    logic       flush_in;
    logic       flush_out;
    logic       need_flush;
    logic [5:0] shift_bits;
    mask_t      size_mask;
    xlen_t      load_shifted;
    xlen_t      load_data;
    logic       tag_need_to_wb;
    preg_t      tag_prd;
    logic       tag_robidx_flag;
    robidx_t    tag_robidx;

    // the wrap flag flips each time the rob index wraps around.
    function automatic logic flush_is_older(input logic flush_flag, input robidx_t flush_idx,
                                            input logic flag, input robidx_t idx);
        return ((flush_idx < idx) && (flush_flag == flag)) ||
               ((flush_idx > idx) && (flush_flag != flag));
    endfunction

    assign ls_address = instr.src1 + instr.imm;
    assign is_mem_op  = instr_valid & (instr.is_load | instr.is_store);
    assign in_mmio    = (ls_address >= mmio_base) & (ls_address <= mmio_limit);
    assign shift_bits = {ls_address[2:0], 3'b000}; // byte offset in bits.

    assign flush_in   = flush_valid & instr_valid &
                        flush_is_older(flush_robidx_flag, flush_robidx,
                                       instr.robidx_flag, instr.robidx);
    assign flush_out  = flush_valid & (state == s_outstanding) &
                        flush_is_older(flush_robidx_flag, flush_robidx,
                                       tag_robidx_flag, tag_robidx);
    assign need_flush   = flush_in | flush_out;
    assign dcache_flush = need_flush;

    assign mmio_fire = is_mem_op & in_mmio & (state == s_idle) & ~need_flush;
    assign req_valid = is_mem_op & ~in_mmio & (state != s_outstanding) & ~need_flush;
    assign req_fire  = req_valid & req_ready;

    always_comb begin
        if (instr.ls_size[0]) begin
            size_mask = 64'h0000_0000_0000_00ff;
        end else if (instr.ls_size[1]) begin
            size_mask = 64'h0000_0000_0000_ffff;
        end else if (instr.ls_size[2]) begin
            size_mask = 64'h0000_0000_ffff_ffff;
        end else begin
            size_mask = '1; // doubles are always aligned.
        end
    end

    always_comb begin
        req.index      = ls_address;
        req.write_data = instr.is_store ? (instr.src2 << shift_bits) : '0;
        req.write_mask = instr.is_store ? (size_mask << shift_bits) : '0;
        req.op_type    = instr.is_store ? tbus_write : tbus_read;
    end

    // bring the addressed bytes down to bit 0 before extending.
    assign load_shifted = read_data >> shift_bits;

    always_comb begin
        if (instr.ls_size[0]) begin
            load_data = instr.is_unsigned ? {56'b0, load_shifted[7:0]}
                                          : {{56{load_shifted[7]}}, load_shifted[7:0]};
        end else if (instr.ls_size[1]) begin
            load_data = instr.is_unsigned ? {48'b0, load_shifted[15:0]}
                                          : {{48{load_shifted[15]}}, load_shifted[15:0]};
        end else if (instr.ls_size[2]) begin
            load_data = instr.is_unsigned ? {32'b0, load_shifted[31:0]}
                                          : {{32{load_shifted[31]}}, load_shifted[31:0]};
        end else begin
            load_data = read_data;
        end
    end

    // an MMIO access sits in outstanding for one cycle and completes on mmio_q.
    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (mmio_fire || req_fire) begin
                    state_next = s_outstanding;
                end else if (req_valid) begin
                    state_next = s_pending;
                end
            end
            s_pending: begin
                if (req_fire) begin
                    state_next = s_outstanding;
                end
            end
            s_outstanding: begin
                if (done || mmio_q) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
        if (need_flush) begin
            state_next = s_idle; // drop the instruction at once.
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state  <= s_idle;
            mmio_q <= 1'b0;
        end else begin
            state  <= state_next;
            mmio_q <= mmio_fire;
        end
    end

    always_ff @(posedge clock) begin
        if (req_fire || mmio_fire) begin
            tag_need_to_wb  <= instr.is_load;
            tag_prd         <= instr.prd;
            tag_robidx_flag <= instr.robidx_flag;
            tag_robidx      <= instr.robidx;
        end
    end

    assign mem_stall   = (state != s_idle) | req_valid | mmio_fire;
    assign instr_ready = ~mem_stall;

    always_comb begin
        wb_out.valid       = (state == s_outstanding) & (done | mmio_q) & ~need_flush;
        wb_out.need_to_wb  = tag_need_to_wb;
        wb_out.prd         = tag_prd;
        wb_out.mmio        = mmio_q;
        wb_out.robidx_flag = tag_robidx_flag;
        wb_out.robidx      = tag_robidx;
        wb_out.data        = mmio_q ? '0 : load_data; // no MMIO devices behind the window.
    end

endmodule

// File: hdl/ifetch.sv
`timescale 1ns/1ps

module ifetch
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      fetch_valid,
    input  xlen_t     fetch_pc,
    output logic      fetch_ready,
    output logic      fetch_done,
    output xlen_t     fetch_data,
    output logic      req_valid,
    output tbus_req_t req,
    input  logic      req_ready,
    input  logic      done,
    input  xlen_t     read_data
);

    typedef enum logic {
        f_idle,
        f_wait
    } fetch_state_t;

    fetch_state_t state;
    logic         req_fire;

    assign req_valid = fetch_valid & (state == f_idle);
    assign req_fire  = req_valid & req_ready;

    always_comb begin
        req.index      = {fetch_pc[63:3], 3'b000}; // whole word that holds the pc.
        req.write_data = '0;
        req.write_mask = '0;
        req.op_type    = tbus_read;
    end

    assign fetch_ready = (state == f_idle) & ~fetch_valid;
    assign fetch_done  = (state == f_wait) & done;
    assign fetch_data  = read_data;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= f_idle;
        end else if ((state == f_idle) && req_fire) begin
            state <= f_wait;
        end else if ((state == f_wait) && done) begin
            state <= f_idle;
        end
    end

endmodule

// File: hdl/tbus_arbiter.sv
`timescale 1ns/1ps

module tbus_arbiter
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      lsu_req_valid,
    input  tbus_req_t lsu_req,
    output logic      lsu_req_ready,
    output logic      lsu_done,
    input  logic      ifu_req_valid,
    input  tbus_req_t ifu_req,
    output logic      ifu_req_ready,
    output logic      ifu_done,
    output xlen_t     read_data_out,
    output logic      mem_req_valid,
    output tbus_req_t mem_req,
    input  logic      mem_req_ready,
    input  logic      mem_done,
    input  xlen_t     mem_read_data
);

    typedef enum logic {
        a_idle,
        a_busy
    } arb_state_t;

    arb_state_t state;
    logic       owner_ifu;
    logic       last_ifu;
    logic       sel_ifu;
    logic       sel_lsu;
    logic       accept;

    // on contention the side that did not win last time gets the bus.
    assign sel_ifu = ifu_req_valid & (~lsu_req_valid | ~last_ifu);
    assign sel_lsu = lsu_req_valid & ~sel_ifu;

    assign mem_req_valid = (state == a_idle) & (lsu_req_valid | ifu_req_valid);
    assign mem_req       = sel_ifu ? ifu_req : lsu_req;
    assign accept        = mem_req_valid & mem_req_ready;

    assign lsu_req_ready = (state == a_idle) & mem_req_ready & ~sel_ifu;
    assign ifu_req_ready = (state == a_idle) & mem_req_ready & ~sel_lsu;

    assign lsu_done      = (state == a_busy) & ~owner_ifu & mem_done;
    assign ifu_done      = (state == a_busy) & owner_ifu & mem_done;
    assign read_data_out = mem_read_data; // only meaningful next to a done.

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= a_idle;
            owner_ifu <= 1'b0;
            last_ifu  <= 1'b0;
        end else if ((state == a_idle) && accept) begin
            state     <= a_busy;
            owner_ifu <= sel_ifu;
            last_ifu  <= sel_ifu;
        end else if ((state == a_busy) && mem_done) begin
            state <= a_idle;
        end
    end

endmodule

// File: hdl/tbus_memory.sv
`timescale 1ns/1ps

module tbus_memory
    import core_pkg::*;
#(
    parameter int mem_latency = 2,
    parameter int mem_depth   = 256
) (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      req_valid,
    input  tbus_req_t req,
    output logic      req_ready,
    output logic      done,
    output xlen_t     read_data
);

    // depth is taken as a power of two so the word index simply wraps.
    localparam int idx_w = $clog2(mem_depth);
    localparam int cnt_w = $clog2(mem_latency + 1);

    xlen_t            mem_array [mem_depth];
    logic [idx_w-1:0] word_idx;
    logic [cnt_w-1:0] countdown;
    logic             accept;

    assign word_idx  = req.index[idx_w+2:3];
    assign req_ready = (countdown == '0); // one access at a time.
    assign accept    = req_valid & req_ready;
    assign done      = (countdown == cnt_w'(1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            countdown <= '0;
        end else if (accept) begin
            countdown <= cnt_w'(mem_latency);
        end else if (countdown != '0) begin
            countdown <= countdown - cnt_w'(1);
        end
    end

    // the write lands at acceptance and only the reply is delayed.
    always_ff @(posedge clock) begin
        if (accept) begin
            if (req.op_type == tbus_write) begin
                mem_array[word_idx] <= (mem_array[word_idx] & ~req.write_mask) |
                                       (req.write_data & req.write_mask);
            end
            read_data <= mem_array[word_idx];
        end
    end

endmodule

// File: hdl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
    import core_pkg::*;
#(
    parameter int mem_latency = 2,
    parameter int mem_depth   = 256
) (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      instr_valid,
    input  ls_instr_t instr,
    output logic      instr_ready,
    output logic      mem_stall,
    input  logic      flush_valid,
    input  logic      flush_robidx_flag,
    input  robidx_t   flush_robidx,
    output logic      dcache_flush,
    output wb_out_t   wb_out,
    input  logic      fetch_valid,
    input  xlen_t     fetch_pc,
    output logic      fetch_ready,
    output logic      fetch_done,
    output xlen_t     fetch_data
);

    logic      lsu_req_valid;
    tbus_req_t lsu_req;
    logic      lsu_req_ready;
    logic      lsu_done;
    logic      ifu_req_valid;
    tbus_req_t ifu_req;
    logic      ifu_req_ready;
    logic      ifu_done;
    xlen_t     bus_read_data;   // shared by both requesters.
    logic      mem_req_valid;
    tbus_req_t mem_req;
    logic      mem_req_ready;
    logic      mem_done;
    xlen_t     mem_read_data;

    memblock u_memblock (
        .clock(clock), .reset_n(reset_n),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .mem_stall(mem_stall), .flush_valid(flush_valid),
        .flush_robidx_flag(flush_robidx_flag), .flush_robidx(flush_robidx),
        .dcache_flush(dcache_flush), .req_valid(lsu_req_valid), .req(lsu_req),
        .req_ready(lsu_req_ready), .done(lsu_done), .read_data(bus_read_data),
        .wb_out(wb_out)
    );

    ifetch u_ifetch (
        .clock(clock), .reset_n(reset_n),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_ready(fetch_ready),
        .fetch_done(fetch_done), .fetch_data(fetch_data),
        .req_valid(ifu_req_valid), .req(ifu_req), .req_ready(ifu_req_ready),
        .done(ifu_done), .read_data(bus_read_data)
    );

    tbus_arbiter u_tbus_arbiter (
        .clock(clock), .reset_n(reset_n),
        .lsu_req_valid(lsu_req_valid), .lsu_req(lsu_req),
        .lsu_req_ready(lsu_req_ready), .lsu_done(lsu_done),
        .ifu_req_valid(ifu_req_valid), .ifu_req(ifu_req),
        .ifu_req_ready(ifu_req_ready), .ifu_done(ifu_done),
        .read_data_out(bus_read_data),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .mem_req_ready(mem_req_ready), .mem_done(mem_done),
        .mem_read_data(mem_read_data)
    );

    tbus_memory #(
        .mem_latency(mem_latency),
        .mem_depth  (mem_depth)
    ) u_tbus_memory (
        .clock(clock), .reset_n(reset_n),
        .req_valid(mem_req_valid), .req(mem_req), .req_ready(mem_req_ready),
        .done(mem_done), .read_data(mem_read_data)
    );

endmodule

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import core_pkg::*;
;

    localparam int mem_latency = 2;
    localparam int used_words  = 16;  // words the test writes before it reads them.
    localparam int wait_limit  = 40;

    logic      clock;
    logic      reset_n;
    logic      instr_valid;
    ls_instr_t instr;
    logic      instr_ready;
    logic      mem_stall;
    logic      flush_valid;
    logic      flush_robidx_flag;
    robidx_t   flush_robidx;
    logic      dcache_flush;
    wb_out_t   wb_out;
    logic      fetch_valid;
    xlen_t     fetch_pc;
    logic      fetch_ready;
    logic      fetch_done;
    xlen_t     fetch_data;

    xlen_t shadow [256];
    xlen_t rng_state = 64'd22;
    int    mismatch_count = 0;
    int    timeout_count = 0;
    logic  flush_expected = 1'b0;
    logic  lsu_busy;
    logic  ifu_busy;

    mem_subsystem_top dut0 (
        .clock(clock), .reset_n(reset_n),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .mem_stall(mem_stall), .flush_valid(flush_valid),
        .flush_robidx_flag(flush_robidx_flag), .flush_robidx(flush_robidx),
        .dcache_flush(dcache_flush), .wb_out(wb_out),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_ready(fetch_ready),
        .fetch_done(fetch_done), .fetch_data(fetch_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at time %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
        assert (got === exp)
        else report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // bus ownership as seen from outside the arbiter.
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lsu_busy <= 1'b0;
            ifu_busy <= 1'b0;
        end else begin
            if (dut0.lsu_req_valid && dut0.lsu_req_ready) lsu_busy <= 1'b1;
            else if (dut0.lsu_done) lsu_busy <= 1'b0;
            if (dut0.ifu_req_valid && dut0.ifu_req_ready) ifu_busy <= 1'b1;
            else if (dut0.ifu_done) ifu_busy <= 1'b0;
        end
    end

    lsu_holds_bus: assert property (@(posedge clock) disable iff (!reset_n)
        lsu_busy |-> !dut0.ifu_req_ready)
        else report_mismatch("ifetch ready while memblock owns the bus");
    ifu_holds_bus: assert property (@(posedge clock) disable iff (!reset_n)
        ifu_busy |-> !dut0.lsu_req_ready)
        else report_mismatch("memblock ready while ifetch owns the bus");
    fetch_held_busy: assert property (@(posedge clock) disable iff (!reset_n)
        ifu_busy |-> !fetch_ready)
        else report_mismatch("fetch_ready high while a fetch is outstanding");
    single_done: assert property (@(posedge clock) disable iff (!reset_n)
        !(dut0.lsu_done && dut0.ifu_done))
        else report_mismatch("done pulsed to both requesters");
    flush_only_when_older: assert property (@(posedge clock) disable iff (!reset_n)
        dcache_flush |-> flush_expected)
        else report_mismatch("dcache_flush without an older flush");
    flush_hides_wb: assert property (@(posedge clock) disable iff (!reset_n)
        dcache_flush |-> !wb_out.valid)
        else report_mismatch("writeback in a flush cycle");
    mmio_reads_zero: assert property (@(posedge clock) disable iff (!reset_n)
        (wb_out.valid && wb_out.mmio) |-> (wb_out.data == '0))
        else report_mismatch("MMIO writeback with nonzero data");

    function automatic xlen_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic ls_instr_t make_instr(input logic is_load, input xlen_t addr,
                                             input int size_log, input logic uns,
                                             input xlen_t data);
        ls_instr_t ins;
        xlen_t     r;
        r = next_rand();
        ins.prd         = r[5:0];
        ins.is_load     = is_load;
        ins.is_store    = !is_load;
        ins.is_unsigned = uns;
        ins.imm         = {{57{r[14]}}, r[14:8]};  // small signed offset.
        ins.src1        = addr - ins.imm;
        ins.src2        = data;
        ins.ls_size     = 4'b0001 << size_log;
        ins.robidx_flag = r[20];
        ins.robidx      = r[28:24];
        return ins;
    endfunction

    // picks the lanes out of the word, then fills the upper bits.
    function automatic xlen_t expected_load(input xlen_t word, input int size_log,
                                            input int off, input logic uns);
        int    nbits;
        xlen_t low;
        xlen_t value;
        nbits = 8 << size_log;
        low   = (nbits == 64) ? '1 : ((64'd1 << nbits) - 64'd1);
        value = (word >> (off * 8)) & low;
        if (!uns && value[nbits-1]) begin
            value = value | ~low;
        end
        return value;
    endfunction

    task automatic check_idle_outputs();
        assert (wb_out.valid === 1'b0) else report_mismatch("wb_out.valid high at reset");
        assert (dcache_flush === 1'b0) else report_mismatch("dcache_flush high at reset");
        assert (fetch_done === 1'b0) else report_mismatch("fetch_done high at reset");
        assert (instr_ready === 1'b1) else report_mismatch("instr_ready low at reset");
        assert (mem_stall === 1'b0) else report_mismatch("mem_stall high at reset");
        assert (fetch_ready === 1'b1) else report_mismatch("fetch_ready low at reset");
    endtask

    // issues a load/store, a fetch or both, and waits until each one completes.
    task automatic run_access(input logic do_ls, input ls_instr_t ins, input logic do_fetch,
                              input xlen_t pc, output wb_out_t wb, output int ls_cycles,
                              output xlen_t fdata, output logic ok);
        int   cycles;
        logic got_wb;
        logic got_f;
        got_wb    = !do_ls;
        got_f     = !do_fetch;
        cycles    = 0;
        ls_cycles = -1;
        wb        = '0;
        fdata     = '0;
        @(posedge clock);
        #1;
        instr       = ins;
        instr_valid = do_ls;
        fetch_pc    = pc;
        fetch_valid = do_fetch;
        while (!(got_wb && got_f) && cycles < wait_limit) begin
            @(negedge clock);
            if (!got_wb && wb_out.valid) begin
                got_wb    = 1'b1;
                wb        = wb_out;
                ls_cycles = cycles;
            end
            if (!got_f && fetch_done) begin
                got_f = 1'b1;
                fdata = fetch_data;
            end
            @(posedge clock);
            #1;
            cycles++;
            if (got_wb) instr_valid = 1'b0;
            if (got_f) fetch_valid = 1'b0;
        end
        ok = got_wb && got_f;
        if (!ok) begin
            timeout_count++;
            $display("timeout: access not finished after %0d cycles", wait_limit);
            instr_valid = 1'b0;
            fetch_valid = 1'b0;
        end
    endtask

    task automatic ls_access(input logic is_load, input int word, input int size_log,
                             input int off, input logic uns, input logic to_mmio);
        ls_instr_t ins;
        wb_out_t   wb;
        int        cycles;
        int        b;
        xlen_t     fdata;
        xlen_t     addr;
        xlen_t     data;
        xlen_t     exp_data;
        logic      ok;
        addr = (xlen_t'(word) << 3) + xlen_t'(off);
        if (to_mmio) addr = addr + mmio_base;  // aliases a used word if it leaked through.
        data     = next_rand();
        exp_data = to_mmio ? '0 : expected_load(shadow[word], size_log, off, uns);
        ins      = make_instr(is_load, addr, size_log, uns, data);
        run_access(1'b1, ins, 1'b0, '0, wb, cycles, fdata, ok);
        if (ok) begin
            check_value("need_to_wb", xlen_t'(wb.need_to_wb), xlen_t'(is_load));
            check_value("prd", xlen_t'(wb.prd), xlen_t'(ins.prd));
            check_value("robidx", xlen_t'(wb.robidx), xlen_t'(ins.robidx));
            check_value("robidx_flag", xlen_t'(wb.robidx_flag), xlen_t'(ins.robidx_flag));
            check_value("mmio flag", xlen_t'(wb.mmio), xlen_t'(to_mmio));
            check_value("latency", xlen_t'(cycles), to_mmio ? 64'd1 : 64'(mem_latency));
            if (is_load || to_mmio) check_value("load data", wb.data, exp_data);
        end
        if (!is_load && !to_mmio) begin
            for (b = 0; b < (1 << size_log); b++) begin
                shadow[word][(off + b) * 8 +: 8] = data[b * 8 +: 8];
            end
        end
    endtask

    task automatic fetch_and_load(input int word, input int fword);
        ls_instr_t ins;
        wb_out_t   wb;
        int        cycles;
        xlen_t     fdata;
        xlen_t     pc;
        logic      ok;
        pc  = (xlen_t'(fword) << 3) + (next_rand() & 64'h7);  // any byte of the word.
        ins = make_instr(1'b1, xlen_t'(word) << 3, 3, 1'b0, '0);
        run_access(1'b1, ins, 1'b1, pc, wb, cycles, fdata, ok);
        if (ok) begin
            check_value("contended load data", wb.data, shadow[word]);
            check_value("fetch data", fdata, shadow[fword]);
        end
    endtask

    // an older flush hits the load a given number of cycles after the bus took it.
    task automatic flush_outstanding(input ls_instr_t ins, input int delay);
        @(posedge clock);
        #1;
        instr       = ins;
        instr_valid = 1'b1;
        repeat (delay) begin
            @(posedge clock);
        end
        #1;
        flush_expected    = 1'b1;
        flush_valid       = 1'b1;
        flush_robidx_flag = 1'b0;
        flush_robidx      = 5'd6;
        @(negedge clock);
        assert (dcache_flush === 1'b1) else report_mismatch("older flush gave no dcache_flush");
        assert (wb_out.valid === 1'b0) else report_mismatch("flushed load wrote back");
        @(posedge clock);
        #1;
        flush_valid = 1'b0;
        instr_valid = 1'b0;
        repeat (mem_latency + 3) begin
            @(negedge clock);
            assert (wb_out.valid === 1'b0) else report_mismatch("flushed load wrote back");
        end
        flush_expected = 1'b0;
    endtask

    task automatic flush_tests(input int word);
        ls_instr_t ins;
        wb_out_t   wb;
        int        cycles;
        xlen_t     fdata;
        logic      ok;
        ins             = make_instr(1'b1, xlen_t'(word) << 3, 3, 1'b0, '0);
        ins.robidx_flag = 1'b0;
        ins.robidx      = 5'd10;
        // younger flushes, once with the same flag and once after a wrap.
        flush_valid       = 1'b1;
        flush_robidx_flag = 1'b0;
        flush_robidx      = 5'd14;
        run_access(1'b1, ins, 1'b0, '0, wb, cycles, fdata, ok);
        if (ok) check_value("load under younger flush", wb.data, shadow[word]);
        flush_robidx_flag = 1'b1;
        flush_robidx      = 5'd3;
        run_access(1'b1, ins, 1'b0, '0, wb, cycles, fdata, ok);
        if (ok) check_value("load under wrapped flush", wb.data, shadow[word]);
        flush_valid = 1'b0;
        // first right after acceptance, then in the very cycle of the done pulse.
        flush_outstanding(ins, 1);
        flush_outstanding(ins, mem_latency);
    endtask

    initial begin
        int i;
        int word;
        int size_log;
        reset_n           = 1'b0;
        instr_valid       = 1'b0;
        instr             = '0;
        flush_valid       = 1'b0;
        flush_robidx_flag = 1'b0;
        flush_robidx      = '0;
        fetch_valid       = 1'b0;
        fetch_pc          = '0;
        repeat (3) begin
            @(negedge clock);
            check_idle_outputs();
            @(posedge clock);
        end
        #1;
        reset_n = 1'b1;
        @(negedge clock);
        check_idle_outputs();

        for (i = 0; i < used_words; i++) begin
            ls_access(1'b0, i, 3, 0, 1'b0, 1'b0);  // fill every used word first.
        end
        for (i = 0; i < 80; i++) begin
            word     = next_rand() % used_words;
            size_log = next_rand() % 4;
            ls_access(next_rand() % 2, word, size_log,
                      (next_rand() % (8 >> size_log)) << size_log, next_rand() % 2, 1'b0);
        end

        ls_access(1'b0, 5, 3, 0, 1'b0, 1'b1);
        ls_access(1'b1, 5, 2, 4, 1'b0, 1'b1);
        ls_access(1'b1, 5, 3, 0, 1'b0, 1'b0);

        for (i = 0; i < 4; i++) begin
            fetch_and_load(next_rand() % used_words, next_rand() % used_words);
        end

        flush_tests(7);
        ls_access(1'b1, 7, 1, 2, 1'b0, 1'b0);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
common/core_pkg.sv
memblock/memblock.sv
hdl/ifetch.sv
hdl/tbus_arbiter.sv
hdl/tbus_memory.sv
hdl/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv
